// ==== logic/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

  ////////////////////////////////////////
  // Serial timing
  ////////////////////////////////////////

  // Clock cycles per serial bit
  localparam int unsigned clks_per_bit = 4;

  // Cycle counter width, plenty of headroom for slower rates
  localparam int unsigned bit_cnt_w = 8;

  ////////////////////////////////////////
  // Buffer sizing
  ////////////////////////////////////////

  // Entries per FIFO, both paths
  localparam int unsigned fifo_depth = 8;

  // Pointer width, log2 of depth
  localparam int unsigned fifo_addr_w = 3;

endpackage

// ==== logic/uart_frame_pkg.sv ====
package uart_frame_pkg;

  // Data bits per frame, sent LSB first
  localparam int unsigned data_bits = 8;

  // One data byte
  typedef logic [data_bits-1:0] byte_t;

  // Receive FIFO entry
  // Byte in the upper bits, error flag in bit 0
  typedef struct packed {
    byte_t data;
    // Stop bit sampled low
    logic  frame_err;
  } rx_entry_t;

endpackage

// ==== logic/uart_fifo.sv ====
`timescale 1ns/1ns

module uart_fifo #(
  parameter type payload_t = uart_frame_pkg::byte_t
) (
  input  logic     i_Clock,
  input  logic     i_rst_n,
  input  logic     i_wr,
  input  payload_t i_wr_data,
  input  logic     i_rd,
  output payload_t o_rd_data,
  output logic     o_empty,
  output logic     o_full
);

  // Storage
  payload_t mem [uart_cfg_pkg::fifo_depth];

  // Pointers and occupancy
  logic [uart_cfg_pkg::fifo_addr_w-1:0] wr_ptr;
  logic [uart_cfg_pkg::fifo_addr_w-1:0] rd_ptr;
  logic [uart_cfg_pkg::fifo_addr_w:0]   count;

  // Qualified strobes
  logic wr_en;
  logic rd_en;

  assign o_empty = (count == '0);
  assign o_full  = (count == (uart_cfg_pkg::fifo_addr_w + 1)'(uart_cfg_pkg::fifo_depth));

  // Drop writes when full, ignore reads when empty
  assign wr_en = i_wr && !o_full;
  assign rd_en = i_rd && !o_empty;

  // Head entry, first word falls through
  assign o_rd_data = mem[rd_ptr];

  always_ff @(posedge i_Clock)
  begin
    if (wr_en)
      mem[wr_ptr] <= i_wr_data;
  end

  always_ff @(posedge i_Clock or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Wrap at last slot
      if (wr_en)
        wr_ptr <= (wr_ptr == (uart_cfg_pkg::fifo_addr_w)'(uart_cfg_pkg::fifo_depth - 1)) ?
                  '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == (uart_cfg_pkg::fifo_addr_w)'(uart_cfg_pkg::fifo_depth - 1)) ?
                  '0 : rd_ptr + 1'b1;
      // Occupancy, unchanged on simultaneous push and pop
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/uart_fifo_tx.sv ====
`timescale 1ns/1ns

module uart_fifo_tx (
  input  logic                  i_Clock,
  input  logic                  i_rst_n,
  input  logic                  i_tx_wr,
  input  uart_frame_pkg::byte_t i_tx_byte,
  input  logic                  i_tx_send,
  output logic                  o_tx_full,
  output logic                  o_tx_active,
  output logic                  o_tx_serial,
  output logic                  o_tx_done
);

  typedef enum logic [2:0] {
    s_idle,
    s_start,
    s_data,
    s_stop,
    s_cleanup
  } tx_state_t;

  tx_state_t                                      state;
  logic [uart_cfg_pkg::bit_cnt_w-1:0]             clk_cnt;
  logic [$clog2(uart_frame_pkg::data_bits)-1:0]   bit_idx;
  uart_frame_pkg::byte_t                          tx_data;
  uart_frame_pkg::byte_t                          head;
  logic                                           fifo_rd;
  logic                                           fifo_empty;
  logic                                           bit_end;
  logic                                           last_bit;
  logic                                           launch;

  ////////////////////////////////////////
  // Transmit buffer
  ////////////////////////////////////////

  uart_fifo #(
    .payload_t (uart_frame_pkg::byte_t)
  ) u_tx_fifo (
    .i_Clock   (i_Clock),
    .i_rst_n   (i_rst_n),
    .i_wr      (i_tx_wr),
    .i_wr_data (i_tx_byte),
    .i_rd      (fifo_rd),
    .o_rd_data (head),
    .o_empty   (fifo_empty),
    .o_full    (o_tx_full)
  );

  ////////////////////////////////////////
  // Frame serializer
  ////////////////////////////////////////

  // Last cycle of the current bit
  assign bit_end  = (clk_cnt == (uart_cfg_pkg::bit_cnt_w)'(uart_cfg_pkg::clks_per_bit - 1));
  assign last_bit = (bit_idx ==
                     ($clog2(uart_frame_pkg::data_bits))'(uart_frame_pkg::data_bits - 1));

  // Idle sees work waiting
  assign launch = (state == s_idle) && i_tx_send && !fifo_empty;

  // Head byte copied at launch, FIFO keeps it until the frame is out
  always_ff @(posedge i_Clock)
  begin
    if (launch)
      tx_data <= head;
  end

  always_ff @(posedge i_Clock or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state       <= s_idle;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      o_tx_serial <= 1'b1;
      o_tx_active <= 1'b0;
      o_tx_done   <= 1'b0;
      fifo_rd     <= 1'b0;
    end
    else
    begin
      // Single cycle strobes
      o_tx_done <= 1'b0;
      fifo_rd   <= 1'b0;
      case (state)
        s_idle:
        begin
          clk_cnt <= '0;
          bit_idx <= '0;
          // Line goes low on the same edge as active
          if (launch)
          begin
            o_tx_active <= 1'b1;
            o_tx_serial <= 1'b0;
            state       <= s_start;
          end
        end
        s_start:
        begin
          if (bit_end)
          begin
            clk_cnt     <= '0;
            o_tx_serial <= tx_data[0];
            state       <= s_data;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        s_data:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            if (last_bit)
            begin
              // Stop bit follows
              bit_idx     <= '0;
              o_tx_serial <= 1'b1;
              state       <= s_stop;
            end
            else
            begin
              bit_idx     <= bit_idx + 1'b1;
              o_tx_serial <= tx_data[bit_idx + 1'b1];
            end
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        s_stop:
        begin
          if (bit_end)
          begin
            // Frame out, release the FIFO entry now
            clk_cnt     <= '0;
            o_tx_active <= 1'b0;
            o_tx_done   <= 1'b1;
            fifo_rd     <= 1'b1;
            state       <= s_cleanup;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        // Pop lands here, idle sees fresh flags
        s_cleanup:
          state <= s_idle;
        default:
          state <= s_idle;
      endcase
    end
  end

endmodule

// ==== logic/uart_fifo_rx.sv ====
`timescale 1ns/1ns

module uart_fifo_rx (
  input  logic                  i_Clock,
  input  logic                  i_rst_n,
  input  logic                  i_rx_serial,
  input  logic                  i_rx_rd,
  output uart_frame_pkg::byte_t o_rx_byte,
  output logic                  o_rx_frame_err,
  output logic                  o_rx_empty,
  output logic                  o_rx_overrun
);

  typedef enum logic [1:0] {
    s_idle,
    s_start,
    s_data,
    s_stop
  } rx_state_t;

  rx_state_t                                      state;
  logic                                           rx_meta;
  logic                                           rx_sync;
  logic                                           rx_prev;
  logic [uart_cfg_pkg::bit_cnt_w-1:0]             clk_cnt;
  logic [$clog2(uart_frame_pkg::data_bits)-1:0]   bit_idx;
  uart_frame_pkg::byte_t                          rx_shift;
  uart_frame_pkg::rx_entry_t                      entry;
  uart_frame_pkg::rx_entry_t                      head;
  logic                                           push;
  logic                                           fifo_full;
  logic                                           bit_end;
  logic                                           half_bit;
  logic                                           sample_data;
  logic                                           sample_stop;

  ////////////////////////////////////////
  // Line synchronizer
  ////////////////////////////////////////

  // Two flops plus one for edge detect, idle line is high
  always_ff @(posedge i_Clock or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= i_rx_serial;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  ////////////////////////////////////////
  // Frame deserializer
  ////////////////////////////////////////

  assign bit_end  = (clk_cnt == (uart_cfg_pkg::bit_cnt_w)'(uart_cfg_pkg::clks_per_bit - 1));
  // Middle of start bit, one cycle already spent detecting the edge
  assign half_bit = (clk_cnt == (uart_cfg_pkg::bit_cnt_w)'((uart_cfg_pkg::clks_per_bit - 1) / 2));

  assign sample_data = (state == s_data) && bit_end;
  assign sample_stop = (state == s_stop) && bit_end;

  // Data shift and entry assembly
  always_ff @(posedge i_Clock)
  begin
    if (sample_data)
      rx_shift <= {rx_sync, rx_shift[uart_frame_pkg::data_bits-1:1]};
    if (sample_stop)
    begin
      entry.data      <= rx_shift;
      entry.frame_err <= !rx_sync;
    end
  end

  always_ff @(posedge i_Clock or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state        <= s_idle;
      clk_cnt      <= '0;
      bit_idx      <= '0;
      push         <= 1'b0;
      o_rx_overrun <= 1'b0;
    end
    else
    begin
      push         <= 1'b0;
      o_rx_overrun <= 1'b0;
      case (state)
        s_idle:
        begin
          clk_cnt <= '0;
          bit_idx <= '0;
          // Falling edge only, a line stuck low starts nothing
          if (rx_prev && !rx_sync)
            state <= s_start;
        end
        s_start:
        begin
          if (half_bit)
          begin
            clk_cnt <= '0;
            // Glitch if line already back high
            state   <= rx_sync ? s_idle : s_data;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        s_data:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == ($clog2(uart_frame_pkg::data_bits))'(uart_frame_pkg::data_bits - 1))
              state <= s_stop;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        s_stop:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            // Full means the entry is lost
            if (fifo_full)
              o_rx_overrun <= 1'b1;
            else
              push <= 1'b1;
            state <= s_idle;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        default:
          state <= s_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Receive buffer
  ////////////////////////////////////////

  // Only pops lower occupancy, so the delayed push always lands
  uart_fifo #(
    .payload_t (uart_frame_pkg::rx_entry_t)
  ) u_rx_fifo (
    .i_Clock   (i_Clock),
    .i_rst_n   (i_rst_n),
    .i_wr      (push),
    .i_wr_data (entry),
    .i_rd      (i_rx_rd),
    .o_rd_data (head),
    .o_empty   (o_rx_empty),
    .o_full    (fifo_full)
  );

  // Head always visible
  assign o_rx_byte      = head.data;
  assign o_rx_frame_err = head.frame_err;

endmodule

// ==== logic/uart_fifo_top.sv ====
`timescale 1ns/1ns

module uart_fifo_top (
  input  logic                  i_Clock,
  input  logic                  i_rst_n,
  // Transmit side
  input  logic                  i_tx_wr,
  input  uart_frame_pkg::byte_t i_tx_byte,
  input  logic                  i_tx_send,
  output logic                  o_tx_full,
  output logic                  o_tx_active,
  output logic                  o_tx_serial,
  output logic                  o_tx_done,
  // Receive side
  input  logic                  i_rx_serial,
  input  logic                  i_rx_rd,
  output uart_frame_pkg::byte_t o_rx_byte,
  output logic                  o_rx_frame_err,
  output logic                  o_rx_empty,
  output logic                  o_rx_overrun
);

  // Independent paths, loopback is external
  uart_fifo_tx u_uart_fifo_tx (
    .i_Clock     (i_Clock),
    .i_rst_n     (i_rst_n),
    .i_tx_wr     (i_tx_wr),
    .i_tx_byte   (i_tx_byte),
    .i_tx_send   (i_tx_send),
    .o_tx_full   (o_tx_full),
    .o_tx_active (o_tx_active),
    .o_tx_serial (o_tx_serial),
    .o_tx_done   (o_tx_done)
  );

  uart_fifo_rx u_uart_fifo_rx (
    .i_Clock        (i_Clock),
    .i_rst_n        (i_rst_n),
    .i_rx_serial    (i_rx_serial),
    .i_rx_rd        (i_rx_rd),
    .o_rx_byte      (o_rx_byte),
    .o_rx_frame_err (o_rx_frame_err),
    .o_rx_empty     (o_rx_empty),
    .o_rx_overrun   (o_rx_overrun)
  );

endmodule

// ==== verif/uart_fifo_top_asserts.sv ====
`timescale 1ns/1ns

module uart_fifo_top_asserts (
  input logic i_Clock,
  input logic i_rst_n,
  input logic o_tx_active,
  input logic o_tx_serial,
  input logic o_tx_done
);

  // Count of failed assertions
  int unsigned fail_cnt = 0;

  // Done is a single cycle strobe
  tx_done_one_cycle: assert property (
    @(posedge i_Clock) disable iff (!i_rst_n)
    o_tx_done |=> !o_tx_done
  )
  else
  begin
    fail_cnt++;
    $error("o_tx_done held high for more than one cycle");
  end

  // Line rests high between frames
  tx_idle_high: assert property (
    @(posedge i_Clock) disable iff (!i_rst_n)
    !o_tx_active |-> o_tx_serial
  )
  else
  begin
    fail_cnt++;
    $error("o_tx_serial low while the transmitter is idle");
  end

  // Done only once the frame is over
  tx_done_not_active: assert property (
    @(posedge i_Clock) disable iff (!i_rst_n)
    !(o_tx_done && o_tx_active)
  )
  else
  begin
    fail_cnt++;
    $error("o_tx_done high while o_tx_active is high");
  end

endmodule

bind uart_fifo_top uart_fifo_top_asserts u_uart_fifo_top_asserts (.*);

// ==== verif/uart_fifo_top_tb.sv ====
`timescale 1ns/1ns

module uart_fifo_top_tb;

  ////////////////////////////////////////
  // Run length
  ////////////////////////////////////////

  localparam int unsigned loop_frames  = 20;
  // Shape 1, loopback, full 8, framing 2, overrun 9
  localparam int unsigned total_frames = 1 + loop_frames + 8 + 2 + 9;
  localparam int unsigned timeout_ns   =
    total_frames * 10 * uart_cfg_pkg::clks_per_bit * 4 * 3;

  logic                  i_Clock;
  logic                  i_rst_n;
  logic                  i_tx_wr;
  uart_frame_pkg::byte_t i_tx_byte;
  logic                  i_tx_send;
  logic                  o_tx_full;
  logic                  o_tx_active;
  logic                  o_tx_serial;
  logic                  o_tx_done;
  logic                  i_rx_serial = 1'b1;
  logic                  i_rx_rd;
  uart_frame_pkg::byte_t o_rx_byte;
  logic                  o_rx_frame_err;
  logic                  o_rx_empty;
  logic                  o_rx_overrun;

  // Line takeover for hand-made frames
  logic line_sel;
  logic line_bit;

  // Model state
  uart_frame_pkg::byte_t     tx_q[$];
  uart_frame_pkg::rx_entry_t rx_q[$];
  int unsigned               err_cnt;
  int unsigned               done_cnt;
  int unsigned               overrun_cnt;
  int unsigned               exp_overrun;

  // Loopback stimulus drawn up front
  uart_frame_pkg::byte_t rand_byte [loop_frames];
  int unsigned           rand_gap  [loop_frames];

  uart_fifo_top u_uart_fifo_top (
    .i_Clock        (i_Clock),
    .i_rst_n        (i_rst_n),
    .i_tx_wr        (i_tx_wr),
    .i_tx_byte      (i_tx_byte),
    .i_tx_send      (i_tx_send),
    .o_tx_full      (o_tx_full),
    .o_tx_active    (o_tx_active),
    .o_tx_serial    (o_tx_serial),
    .o_tx_done      (o_tx_done),
    .i_rx_serial    (i_rx_serial),
    .i_rx_rd        (i_rx_rd),
    .o_rx_byte      (o_rx_byte),
    .o_rx_frame_err (o_rx_frame_err),
    .o_rx_empty     (o_rx_empty),
    .o_rx_overrun   (o_rx_overrun)
  );

  initial
  begin
    i_Clock = 1'b0;
    forever #2 i_Clock = ~i_Clock;
  end

  // Loopback unless a test owns the line
  always @(posedge i_Clock)
    i_rx_serial <= line_sel ? line_bit : o_tx_serial;

  initial
  begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns, the DUT stopped making progress", timeout_ns);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h (at %0t ns)", name, got, exp, $time);
    end
  endtask

  task automatic report_failure(input string what);
    err_cnt++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  // Line level of bit idx in a frame
  function automatic logic frame_bit(input uart_frame_pkg::byte_t b, input int unsigned idx);
    logic v;
    if (idx == 0)
      v = 1'b0;
    else if (idx == 9)
      v = 1'b1;
    else
      v = b[idx-1];
    return v;
  endfunction

  // Entry heading for the receive FIFO is lost if it would be the ninth
  function automatic void predict_rx(input uart_frame_pkg::byte_t b, input logic err);
    uart_frame_pkg::rx_entry_t e;
    e.data      = b;
    e.frame_err = err;
    if (rx_q.size() < uart_cfg_pkg::fifo_depth)
      rx_q.push_back(e);
    else
      exp_overrun++;
  endfunction

  // Model update one cycle ahead of the DUT edge
  always @(negedge i_Clock)
  begin : tx_rx_monitor
    logic accept;
    if (i_rst_n)
    begin
      compare_value("o_tx_full", o_tx_full, tx_q.size() == uart_cfg_pkg::fifo_depth);
      accept = i_tx_wr && (tx_q.size() < uart_cfg_pkg::fifo_depth);
      if (o_tx_done)
      begin
        done_cnt++;
        if (tx_q.size() == 0)
          report_failure("o_tx_done pulsed with no byte left in the transmit model");
        else
          predict_rx(tx_q.pop_front(), 1'b0);
      end
      if (accept)
        tx_q.push_back(i_tx_byte);
      if (o_rx_overrun)
        overrun_cnt++;
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic write_byte(input uart_frame_pkg::byte_t b);
    @(posedge i_Clock);
    i_tx_wr   <= 1'b1;
    i_tx_byte <= b;
    @(posedge i_Clock);
    i_tx_wr   <= 1'b0;
  endtask

  // Waits for data, checks the head against the model, then pops
  task automatic pop_check();
    @(negedge i_Clock);
    while (o_rx_empty)
      @(negedge i_Clock);
    if (rx_q.size() == 0)
      report_failure("receive FIFO holds an entry that the model did not predict");
    else
    begin
      compare_value("o_rx_byte", o_rx_byte, rx_q[0].data);
      compare_value("o_rx_frame_err", o_rx_frame_err, rx_q[0].frame_err);
    end
    @(posedge i_Clock);
    i_rx_rd <= 1'b1;
    if (rx_q.size() != 0)
      rx_q.delete(0);
    @(posedge i_Clock);
    i_rx_rd <= 1'b0;
  endtask

  task automatic inject_frame(input uart_frame_pkg::byte_t b, input logic stop);
    logic [9:0] bits;
    int         i;
    bits = {stop, b, 1'b0};
    @(posedge i_Clock);
    line_sel <= 1'b1;
    line_bit <= 1'b1;
    for (i = 0; i < 10; i++)
    begin
      @(posedge i_Clock);
      line_bit <= bits[i];
      repeat (uart_cfg_pkg::clks_per_bit - 1) @(posedge i_Clock);
    end
    // One idle bit before the line goes back to loopback
    @(posedge i_Clock);
    line_bit <= 1'b1;
    repeat (uart_cfg_pkg::clks_per_bit) @(posedge i_Clock);
    line_sel <= 1'b0;
    predict_rx(b, !stop);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    int unsigned           done_base;
    uart_frame_pkg::byte_t shape_byte;
    int                    i;
    void'($urandom(32'ha629));
    for (i = 0; i < loop_frames; i++)
    begin
      rand_byte[i] = uart_frame_pkg::byte_t'($urandom);
      rand_gap[i]  = $urandom % 8;
    end
    shape_byte  = uart_frame_pkg::byte_t'($urandom);
    i_rst_n     = 1'b0;
    i_tx_wr     = 1'b0;
    i_tx_byte   = '0;
    i_tx_send   = 1'b0;
    i_rx_rd     = 1'b0;
    line_sel    = 1'b0;
    line_bit    = 1'b1;
    err_cnt     = 0;
    done_cnt    = 0;
    overrun_cnt = 0;
    exp_overrun = 0;
    repeat (5) @(posedge i_Clock);
    i_rst_n <= 1'b1;

    // Reset values
    @(negedge i_Clock);
    compare_value("o_tx_serial", o_tx_serial, 1'b1);
    compare_value("o_tx_active", o_tx_active, 1'b0);
    compare_value("o_tx_done", o_tx_done, 1'b0);
    compare_value("o_tx_full", o_tx_full, 1'b0);
    compare_value("o_rx_overrun", o_rx_overrun, 1'b0);
    compare_value("o_rx_empty", o_rx_empty, 1'b1);

    // Frame shape sampled mid-bit from the rise of active
    write_byte(shape_byte);
    i_tx_send <= 1'b1;
    @(negedge i_Clock);
    while (!o_tx_active)
      @(negedge i_Clock);
    repeat (uart_cfg_pkg::clks_per_bit / 2) @(negedge i_Clock);
    for (i = 0; i < 10; i++)
    begin
      compare_value("o_tx_serial", o_tx_serial, frame_bit(shape_byte, i));
      if (i < 9)
        repeat (uart_cfg_pkg::clks_per_bit) @(negedge i_Clock);
    end
    pop_check();

    // Random loopback with writer and reader side by side
    done_base = done_cnt;
    fork
      begin
        for (int k = 0; k < loop_frames; k++)
        begin
          repeat (rand_gap[k]) @(posedge i_Clock);
          while (tx_q.size() == uart_cfg_pkg::fifo_depth)
            @(posedge i_Clock);
          write_byte(rand_byte[k]);
        end
      end
      repeat (loop_frames) pop_check();
    join
    compare_value("o_tx_done pulses", done_cnt - done_base, loop_frames);

    // Transmit FIFO full drops the ninth byte
    @(posedge i_Clock);
    i_tx_send <= 1'b0;
    for (i = 0; i < 9; i++)
    begin
      write_byte(uart_frame_pkg::byte_t'($urandom));
      @(negedge i_Clock);
      compare_value("o_tx_full", o_tx_full, i >= 7);
    end
    done_base = done_cnt;
    @(posedge i_Clock);
    i_tx_send <= 1'b1;
    repeat (uart_cfg_pkg::fifo_depth) pop_check();
    compare_value("o_tx_done pulses", done_cnt - done_base, uart_cfg_pkg::fifo_depth);
    @(negedge i_Clock);
    compare_value("o_rx_empty", o_rx_empty, 1'b1);

    // Low stop bit then a clean frame
    inject_frame(uart_frame_pkg::byte_t'($urandom), 1'b0);
    pop_check();
    inject_frame(uart_frame_pkg::byte_t'($urandom), 1'b1);
    pop_check();

    // Nine frames with no pops
    for (i = 0; i < 9; i++)
    begin
      while (tx_q.size() == uart_cfg_pkg::fifo_depth)
        @(posedge i_Clock);
      write_byte(uart_frame_pkg::byte_t'($urandom));
    end
    @(negedge i_Clock);
    while (overrun_cnt == 0)
      @(negedge i_Clock);
    repeat (uart_cfg_pkg::fifo_depth) pop_check();
    @(negedge i_Clock);
    compare_value("o_rx_empty", o_rx_empty, 1'b1);
    compare_value("o_rx_overrun pulses", overrun_cnt, exp_overrun);

    repeat (uart_cfg_pkg::clks_per_bit) @(posedge i_Clock);
    // Bound assertion failures count as errors too
    err_cnt = err_cnt + u_uart_fifo_top.u_uart_fifo_top_asserts.fail_cnt;
    $display("Errors: %0d, o_tx_done pulses: %0d, o_rx_overrun pulses: %0d",
             err_cnt, done_cnt, overrun_cnt);
    if (err_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== uart_fifo_top.f ====
logic/uart_cfg_pkg.sv
logic/uart_frame_pkg.sv
logic/uart_fifo.sv
logic/uart_fifo_tx.sv
logic/uart_fifo_rx.sv
logic/uart_fifo_top.sv
verif/uart_fifo_top_asserts.sv
verif/uart_fifo_top_tb.sv

// ==== Makefile ====
TOP := uart_fifo_top_tb

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	verilator --lint-only --timing --top-module $(TOP) -f uart_fifo_top.f

# Build, run, and pass only when the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP) -f uart_fifo_top.f
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Test completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
